// File: Makefile
# Verilator simulation of the SAM Coupe ASIC I/O block

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fails if the run reports failure"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
		--top-module tb_sam_asic -f all.f --Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb +verilator+error+limit+100 | tee sim.log
	@grep -q "STATUS: PASS" sim.log
	@! grep -q "STATUS: FAIL" sim.log

clean:
	rm -rf obj_dir sim.log

// File: all.f
src/sam_pkg.sv
src/sam_port_regs.sv
src/sam_mem_map.sv
src/sam_midi_tx.sv
src/sam_audio_mix.sv
src/sam_asic.sv
bench/sam_asic_sva.sv
bench/tb_sam_asic.sv

// File: bench/sam_asic_sva.sv
//======================================================================
// Concurrent assertions on the ASIC top level
// Write strobe width, MIDI flag relation, RAM write against ROM selects
//======================================================================

`timescale 1ns/1ns

module sam_asic_sva (
	input logic                clk_sys,
	input logic                reset,
	input sam_pkg::io_write_t  io_wr,
	input logic                midi_tx,
	input logic                int_midi,
	input sam_pkg::mem_sel_t   mem
);

	// Number of failed assertions so far
	int unsigned fail_count = 0;

	// A port write event lasts exactly one cycle
	strobe_single: assert property (
		@(posedge clk_sys) disable iff (reset)
		io_wr.strobe |=> !io_wr.strobe
	) else begin
		fail_count++;
		$error("io_wr strobe high for two cycles in a row");
	end

	midi_int_in_frame: assert property (
		@(posedge clk_sys) disable iff (reset)
		int_midi |-> midi_tx
	) else begin
		fail_count++;
		$error("int_midi high while midi_tx is low");
	end

	// No RAM write while a ROM is mapped at the address
	we_not_rom: assert property (
		@(posedge clk_sys) disable iff (reset)
		!(mem.ram_we && (mem.rom0_sel || mem.rom1_sel))
	) else begin
		fail_count++;
		$error("ram_we together with a ROM select");
	end

endmodule

bind sam_asic sam_asic_sva chk (
	.clk_sys  (clk_sys),
	.reset    (reset),
	.io_wr    (io_wr),
	.midi_tx  (midi_tx),
	.int_midi (int_midi),
	.mem      (mem)
);

// File: bench/tb_sam_asic.sv
//======================================================================
// Testbench for the SAM Coupe ASIC I/O block
// Random port, paging, audio and MIDI stimulus against a local model
//======================================================================

`timescale 1ns/1ns

module tb_sam_asic;

	localparam int TICK_CYCLES = 96;
	localparam int N_OPS       = 480;
	localparam int OP_CYCLES   = 8;
	// Three MIDI frames in all, plus a margin of 400 ticks
	localparam int WATCHDOG_CYCLES = N_OPS * OP_CYCLES + (3 * 320 + 400) * TICK_CYCLES;

	logic              clk_sys;
	logic              reset;
	sam_pkg::cpu_bus_t bus;
	logic              ext_ram_off;
	logic [7:0]        psg_l;
	logic [7:0]        psg_r;
	logic [7:0]        rdata;
	sam_pkg::mem_sel_t mem;
	logic              midi_tx;
	logic [15:0]       audio_l;
	logic [15:0]       audio_r;

	// Model of the ASIC registers
	logic [7:0] m_lmpr;
	logic [7:0] m_hmpr;
	logic [7:0] m_border;
	logic [7:0] m_ext_c;
	logic [7:0] m_ext_d;
	logic       m_ext_dis;
	logic [7:0] m_dac_data;
	logic [7:0] m_dac_l;
	logic [7:0] m_dac_r;
	logic       m_old_stb;

	string cur_test;
	int    checks;
	int    errors;
	int    test_checks;
	int    test_errors;
	int    tests_run;
	int    tests_failed;

	sam_asic uut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("ERROR: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
		$display("STATUS: FAIL");
		$finish;
	end

	task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("MISMATCH %s %s: expected 0x%0h actual 0x%0h", cur_test, what, exp, act);
		end
	endtask

	task automatic start_test(input string name);
		cur_test    = name;
		test_checks = checks;
		test_errors = errors;
	endtask

	task automatic end_test();
		tests_run++;
		if (errors != test_errors) tests_failed++;
		$display("test %s done: %0d checks, %0d errors", cur_test,
			checks - test_checks, errors - test_errors);
	endtask

	task automatic model_write(input logic [7:0] port, input logic [7:0] data);
		case (port)
			sam_pkg::PORT_LMPR:     m_lmpr     = data;
			sam_pkg::PORT_HMPR:     m_hmpr     = data;
			sam_pkg::PORT_BORDER:   m_border   = data;
			sam_pkg::PORT_EXT_C:    m_ext_c    = data;
			sam_pkg::PORT_EXT_D:    m_ext_d    = data;
			sam_pkg::PORT_LPT_DATA: m_dac_data = data;
			sam_pkg::PORT_LPT_STB: begin
				if (!m_old_stb && data[0]) m_dac_l = m_dac_data;
				if (m_old_stb && !data[0]) m_dac_r = m_dac_data;
				m_old_stb = data[0];
			end
			default: ;
		endcase
	endtask

	task automatic apply_reset(input logic ram_off);
		@(posedge clk_sys);
		#1;
		bus         = '0;
		ext_ram_off = ram_off;
		reset       = 1'b1;
		repeat (2) @(posedge clk_sys);
		#1;
		reset      = 1'b0;
		{m_lmpr, m_hmpr, m_border, m_ext_c, m_ext_d} = '0;
		{m_dac_data, m_dac_l, m_dac_r, m_old_stb} = '0;
		m_ext_dis  = ram_off;
	endtask

	// One I/O cycle on the bus, write or read
	task automatic drive_io(input logic [7:0] port, input logic [7:0] data, input logic write);
		@(posedge clk_sys);
		#1;
		bus       = '0;
		bus.addr  = {8'($urandom), port};
		bus.wdata = data;
		bus.iorq  = 1'b1;
		bus.m1    = 1'b1;
		bus.wr    = write;
		bus.rd    = !write;
	endtask

	task automatic port_write(input logic [7:0] port, input logic [7:0] data, input int hold);
		drive_io(port, data, 1'b1);
		repeat (hold) @(posedge clk_sys);
		#1;
		bus = '0;
		@(posedge clk_sys);
		#1;
		model_write(port, data);
	endtask

	task automatic port_read(input logic [7:0] port, output logic [7:0] data);
		drive_io(port, 8'h00, 1'b0);
		#2;
		data = rdata;
	endtask

	function automatic sam_pkg::mem_sel_t exp_mem(input sam_pkg::cpu_bus_t b);
		sam_pkg::mem_sel_t m;
		logic [1:0]        q;
		logic              rom0;
		logic              rom1;
		logic              wp;
		logic              ext;
		logic              ena;
		int                page;
		q    = b.addr[15:14];
		rom0 = !m_lmpr[5] && q == 2'd0;
		rom1 = m_lmpr[6] && q == 2'd3;
		wp   = m_lmpr[7] && q == 2'd0;
		ext  = m_hmpr[7] && b.addr[15];
		ena  = !(ext && m_ext_dis);
		case (q)
			2'd0: page = int'(m_lmpr[4:0]);
			2'd1: page = int'(m_lmpr[4:0]) + 1;
			2'd2: page = int'(m_hmpr[4:0]);
			default: page = int'(m_hmpr[4:0]) + 1;
		endcase
		if (ext) page = 256 + int'(b.addr[14] ? m_ext_d : m_ext_c);
		m.ram_page    = 9'(page);
		m.rom0_sel    = rom0;
		m.rom1_sel    = rom1;
		m.ext_ena     = ena;
		m.ram_we      = b.mreq && b.wr && ena && !rom0 && !rom1 && !wp;
		m.ram_rd      = b.mreq && b.rd && !rom0 && !rom1;
		m.rom_addr_hi = {b.addr[15], rom1};
		return m;
	endfunction

	function automatic logic [15:0] exp_audio(input logic [7:0] psg, input logic beep,
		input logic [7:0] dac);
		int sum;
		sum = int'(psg) * 1028 + int'(beep) * 131072 + int'(dac) * 1028;
		// Sum is 19 bits wide before the shift
		sum = sum % (1 << 19);
		return 16'(sum >> 3);
	endfunction

	task automatic check_audio();
		@(posedge clk_sys);
		#1;
		psg_l = 8'($urandom);
		psg_r = 8'($urandom);
		#2;
		check_val("audio_l", exp_audio(psg_l, m_border[4], m_dac_l), audio_l);
		check_val("audio_r", exp_audio(psg_r, m_border[4], m_dac_r), audio_r);
	endtask

	//==================================================================
	// MIDI frame, times counted in cycles from the rise of midi_tx
	//==================================================================
	task automatic midi_frame(input logic second_write);
		logic [7:0] st;
		int         cnt;
		int         t_int;
		int         t_int_clr;
		int         t_fall;
		int         frame_len;
		t_int     = -1;
		t_int_clr = -1;
		t_fall    = -1;
		frame_len = (second_write ? 640 : 320) * TICK_CYCLES;
		port_write(sam_pkg::PORT_MIDI, 8'($urandom), 1);
		// Write event was two cycles back
		cnt = 1;
		while (!midi_tx && cnt < 200) begin
			port_read(sam_pkg::PORT_STATUS, st);
			cnt++;
		end
		checks++;
		assert (midi_tx && cnt <= 97) else begin
			errors++;
			$display("ERROR %s: midi_tx did not rise within 97 cycles of the write", cur_test);
		end
		cnt = 0;
		while (t_fall < 0 && cnt < frame_len + 8) begin
			if (second_write && cnt == 1000) begin
				drive_io(sam_pkg::PORT_MIDI, 8'($urandom), 1'b1);
				#2;
				st = 8'hFF;
			end else begin
				port_read(sam_pkg::PORT_STATUS, st);
			end
			cnt++;
			if (t_int < 0 && !st[4]) t_int = cnt;
			else if (t_int >= 0 && t_int_clr < 0 && st[4]) t_int_clr = cnt;
			if (!midi_tx) t_fall = cnt;
		end
		checks++;
		assert (t_int >= 304 * TICK_CYCLES && t_int <= 305 * TICK_CYCLES) else begin
			errors++;
			$display("ERROR %s: status bit 4 went low at cycle %0d, outside %0d to %0d",
				cur_test, t_int, 304 * TICK_CYCLES, 305 * TICK_CYCLES);
		end
		check_val("int_midi clear cycle", 320 * TICK_CYCLES, t_int_clr);
		check_val("midi_tx fall cycle", frame_len, t_fall);
	endtask

	initial begin
		logic [7:0] port;
		logic [7:0] data;
		logic [7:0] rd_val;
		bus         = '0;
		reset       = 1'b1;
		ext_ram_off = 1'b0;
		psg_l       = 8'h00;
		psg_r       = 8'h00;
		{checks, errors, tests_run, tests_failed} = '0;
		void'($urandom(34));
		apply_reset(1'b0);

		start_test("reset");
		port_read(sam_pkg::PORT_LMPR, rd_val);
		check_val("lmpr", 8'h00, rd_val);
		port_read(sam_pkg::PORT_HMPR, rd_val);
		check_val("hmpr", 8'h00, rd_val);
		port_read(sam_pkg::PORT_STATUS, rd_val);
		check_val("status bit 4", 1'b1, rd_val[4]);
		check_val("midi_tx", 1'b0, midi_tx);
		repeat (4) check_audio();
		end_test();

		start_test("port_regs");
		for (int i = 0; i < 20; i++) begin
			port = $urandom_range(0, 1) ? sam_pkg::PORT_HMPR : sam_pkg::PORT_LMPR;
			data = 8'($urandom);
			port_write(port, data, $urandom_range(1, 4));
			port_read(port, rd_val);
			check_val("written register", data, rd_val);
			port_read(sam_pkg::PORT_LMPR, rd_val);
			check_val("lmpr", m_lmpr, rd_val);
			port_read(sam_pkg::PORT_HMPR, rd_val);
			check_val("hmpr", m_hmpr, rd_val);
		end
		for (int i = 0; i < 20; i++) begin
			port = 8'($urandom);
			if (port inside {sam_pkg::PORT_STATUS, sam_pkg::PORT_LMPR, sam_pkg::PORT_HMPR,
				sam_pkg::PORT_LPT_DATA, sam_pkg::PORT_LPT_STB}) port = 8'h00;
			port_read(port, rd_val);
			check_val("unmapped port", 8'hFF, rd_val);
		end
		end_test();

		start_test("paging");
		for (int r = 0; r < 4; r++) begin
			apply_reset(1'($urandom));
			for (int i = 0; i < 6; i++) begin
				port_write(sam_pkg::PORT_LMPR, 8'($urandom), 1);
				port_write(sam_pkg::PORT_HMPR, 8'($urandom), 1);
				port_write(sam_pkg::PORT_EXT_C, 8'($urandom), 1);
				port_write(sam_pkg::PORT_EXT_D, 8'($urandom), 1);
				for (int j = 0; j < 8; j++) begin
					@(posedge clk_sys);
					#1;
					bus      = '0;
					bus.addr = 16'($urandom);
					bus.mreq = 1'($urandom);
					bus.rd   = 1'($urandom);
					bus.wr   = 1'($urandom);
					#2;
					check_val("mem", exp_mem(bus), mem);
				end
			end
		end
		end_test();

		start_test("audio");
		for (int i = 0; i < 40; i++) begin
			case ($urandom_range(0, 3))
				0: port_write(sam_pkg::PORT_BORDER, 8'($urandom), 1);
				1: port_write(sam_pkg::PORT_LPT_DATA, 8'($urandom), 1);
				default: port_write(sam_pkg::PORT_LPT_STB, 8'($urandom), 1);
			endcase
			check_audio();
		end
		end_test();

		start_test("midi");
		midi_frame(1'b0);
		midi_frame(1'b1);
		end_test();

		$display("summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
			tests_run, tests_failed, checks, errors, uut.chk.fail_count);
		if (errors == 0 && uut.chk.fail_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// File: src/sam_asic.sv
//======================================================================
// SAM Coupe ASIC I/O side, top level
// Port registers, paging map, MIDI timer and audio mixer
//======================================================================

`timescale 1ns/1ns

module sam_asic (
	input  logic                             clk_sys,
	input  logic                             reset,
	input  sam_pkg::cpu_bus_t                bus,
	input  logic                             ext_ram_off,
	input  logic [7:0]                       psg_l,
	input  logic [7:0]                       psg_r,
	output logic [7:0]                       rdata,
	output sam_pkg::mem_sel_t                mem,
	output logic                             midi_tx,
	output logic [sam_pkg::AUDIO_OUT_W-1:0]  audio_l,
	output logic [sam_pkg::AUDIO_OUT_W-1:0]  audio_r
);

	sam_pkg::io_write_t  io_wr;
	sam_pkg::page_regs_t page_regs;
	logic                ear;
	logic                int_midi;

	sam_port_regs u_port_regs (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.bus         (bus),
		.ext_ram_off (ext_ram_off),
		.int_midi    (int_midi),
		.io_wr       (io_wr),
		.page_regs   (page_regs),
		.ear         (ear),
		.rdata       (rdata)
	);

	sam_mem_map u_mem_map (
		.bus       (bus),
		.page_regs (page_regs),
		.mem       (mem)
	);

	// 1 MHz tick unused at this level
	sam_midi_tx u_midi_tx (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.io_wr    (io_wr),
		.midi_tx  (midi_tx),
		.int_midi (int_midi),
		.tick_1m  ()
	);

	sam_audio_mix u_audio_mix (
		.clk_sys (clk_sys),
		.reset   (reset),
		.io_wr   (io_wr),
		.ear     (ear),
		.psg_l   (psg_l),
		.psg_r   (psg_r),
		.audio_l (audio_l),
		.audio_r (audio_r)
	);

endmodule

// File: src/sam_audio_mix.sv
//======================================================================
// Audio mixer
// Printer port DAC data register and left/right latches
// Sound chip, border beeper and DAC sum per channel
//======================================================================

`timescale 1ns/1ns

module sam_audio_mix (
	input  logic                              clk_sys,
	input  logic                              reset,
	input  sam_pkg::io_write_t                io_wr,
	input  logic                              ear,
	input  logic [7:0]                        psg_l,
	input  logic [7:0]                        psg_r,
	output logic [sam_pkg::AUDIO_OUT_W-1:0]   audio_l,
	output logic [sam_pkg::AUDIO_OUT_W-1:0]   audio_r
);

	logic [7:0]                      dac_data;
	logic [7:0]                      dac_l;
	logic [7:0]                      dac_r;
	logic                            old_stb;
	logic [sam_pkg::AUDIO_SUM_W-1:0] sum_l;
	logic [sam_pkg::AUDIO_SUM_W-1:0] sum_r;

	// psg*1028 + ear*131072 + dac*1028
	function automatic logic [sam_pkg::AUDIO_SUM_W-1:0] chan_sum(
		input logic [7:0] psg,
		input logic       beep,
		input logic [7:0] dac
	);
		logic [sam_pkg::AUDIO_SUM_W-1:0] psg_term;
		logic [sam_pkg::AUDIO_SUM_W-1:0] dac_term;
		logic [sam_pkg::AUDIO_SUM_W-1:0] ear_term;
		psg_term = {psg, psg, 2'b00};
		dac_term = {dac, dac, 2'b00};
		ear_term = {beep, 17'd0};
		return psg_term + ear_term + dac_term;
	endfunction

	//==================================================================
	// Printer port DAC
	//==================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dac_data <= 8'h00;
			dac_l    <= 8'h00;
			dac_r    <= 8'h00;
			old_stb  <= 1'b0;
		end else if (io_wr.strobe) begin
			if (io_wr.port == sam_pkg::PORT_LPT_DATA) begin
				dac_data <= io_wr.data;
			end
			if (io_wr.port == sam_pkg::PORT_LPT_STB) begin
				// Rising strobe feeds left, falling strobe feeds right
				if (~old_stb & io_wr.data[0]) dac_l <= dac_data;
				if (old_stb & ~io_wr.data[0]) dac_r <= dac_data;
				old_stb <= io_wr.data[0];
			end
		end
	end

	assign sum_l   = chan_sum(psg_l, ear, dac_l);
	assign sum_r   = chan_sum(psg_r, ear, dac_r);
	assign audio_l = sum_l[sam_pkg::AUDIO_SUM_W-1:3];
	assign audio_r = sum_r[sam_pkg::AUDIO_SUM_W-1:3];

endmodule

// File: src/sam_mem_map.sv
//======================================================================
// Memory paging map
// RAM page from LMPR/HMPR or the external RAM registers
// ROM selects, write protect, RAM read and write enables
//======================================================================

`timescale 1ns/1ns

module sam_mem_map (
	input  sam_pkg::cpu_bus_t    bus,
	input  sam_pkg::page_regs_t  page_regs,
	output sam_pkg::mem_sel_t    mem
);

	logic [1:0] quarter;
	logic       rom0_sel;
	logic       rom1_sel;
	logic       ram_wp;
	logic       ext_ram;
	logic       ext_ena;
	logic [4:0] page_base;
	logic [8:0] ram_page;

	assign quarter = bus.addr[15:14];

	// ROM0 in the bottom quarter unless paged out, ROM1 in the top quarter
	assign rom0_sel = ~page_regs.lmpr[5] & (quarter == 2'd0);
	assign rom1_sel = page_regs.lmpr[6] & (quarter == 2'd3);
	assign ram_wp   = page_regs.lmpr[7] & (quarter == 2'd0);

	// Upper 32K maps to external RAM when HMPR bit 7 is set
	assign ext_ram = page_regs.hmpr[7] & bus.addr[15];
	assign ext_ena = ~(ext_ram & page_regs.ext_dis);

	// Lower half pages from LMPR, upper half from HMPR
	assign page_base = bus.addr[15] ? page_regs.hmpr[4:0] : page_regs.lmpr[4:0];

	always_comb begin
		if (ext_ram) begin
			ram_page = {1'b1, bus.addr[14] ? page_regs.ext_d : page_regs.ext_c};
		end else begin
			// Odd quarter takes the following page
			ram_page = {4'b0000, page_base} + {8'h00, bus.addr[14]};
		end
	end

	always_comb begin
		mem.ram_page = ram_page;
		mem.rom0_sel = rom0_sel;
		mem.rom1_sel = rom1_sel;
		mem.ext_ena  = ext_ena;
		mem.ram_we   = bus.mreq & bus.wr & ext_ena & ~(rom0_sel | rom1_sel | ram_wp);
		mem.ram_rd   = bus.mreq & bus.rd & ~(rom0_sel | rom1_sel);
		// ROM address bit 15 and the bank in use
		mem.rom_addr_hi = {bus.addr[15], rom1_sel};
	end

endmodule

// File: src/sam_midi_tx.sv
//======================================================================
// MIDI transmit timer
// 1 MHz tick prescaler
// Pending write flag, frame timer, midi_tx and interrupt flag
//======================================================================

`timescale 1ns/1ns

module sam_midi_tx (
	input  logic                clk_sys,
	input  logic                reset,
	input  sam_pkg::io_write_t  io_wr,
	output logic                midi_tx,
	output logic                int_midi,
	output logic                tick_1m
);

	logic [$bits(sam_pkg::TICK_1M_DIV)-1:0]      div;
	logic [$bits(sam_pkg::MIDI_FRAME_TICKS)-1:0] timer;
	logic [$bits(sam_pkg::MIDI_FRAME_TICKS)-1:0] timer_dec;
	logic                                        pending;
	logic                                        midi_wr;

	//==================================================================
	// Prescaler, one tick every TICK_1M_DIV cycles
	//==================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			div     <= '0;
			tick_1m <= 1'b0;
		end else begin
			tick_1m <= (div == sam_pkg::TICK_1M_DIV - 7'd1);
			if (div == sam_pkg::TICK_1M_DIV - 7'd1) begin
				div <= '0;
			end else begin
				div <= div + 1'b1;
			end
		end
	end

	//==================================================================
	// Frame timer
	//==================================================================
	assign midi_wr   = io_wr.strobe & (io_wr.port == sam_pkg::PORT_MIDI);
	assign timer_dec = timer - 1'b1;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pending  <= 1'b0;
			timer    <= '0;
			midi_tx  <= 1'b0;
			int_midi <= 1'b0;
		end else begin
			if (tick_1m) begin
				if (timer != '0) begin
					timer <= timer_dec;
					// Interrupt as the count passes into the last ticks
					if (timer_dec == sam_pkg::MIDI_INT_TICK) begin
						int_midi <= 1'b1;
					end
				end else begin
					midi_tx  <= 1'b0;
					int_midi <= 1'b0;
					if (pending) begin
						midi_tx <= 1'b1;
						timer   <= sam_pkg::MIDI_FRAME_TICKS;
						pending <= 1'b0;
					end
				end
			end

			// A write on the same cycle as a frame start queues the next one
			if (midi_wr) begin
				pending <= 1'b1;
			end
		end
	end

endmodule

// File: src/sam_pkg.sv
//======================================================================
// Shared definitions for the SAM Coupe ASIC I/O block
// Port numbers, MIDI timer constants, audio widths
// Bus, port write, paging and memory select structs
//======================================================================

package sam_pkg;

	//==================================================================
	// ASIC port numbers, decoded from addr[7:0]
	//==================================================================
	localparam logic [7:0] PORT_EXT_C    = 8'd128;
	localparam logic [7:0] PORT_EXT_D    = 8'd129;
	// SID extension port, no longer decoded by the ASIC
	localparam logic [7:0] PORT_SID      = 8'd212;
	localparam logic [7:0] PORT_LPT_DATA = 8'd232;
	localparam logic [7:0] PORT_LPT_STB  = 8'd233;
	localparam logic [7:0] PORT_STATUS   = 8'd249;
	localparam logic [7:0] PORT_LMPR     = 8'd250;
	localparam logic [7:0] PORT_HMPR     = 8'd251;
	localparam logic [7:0] PORT_MIDI     = 8'd253;
	localparam logic [7:0] PORT_BORDER   = 8'd254;

	// clk_sys cycles per 1 MHz tick
	localparam logic [6:0] TICK_1M_DIV      = 7'd96;
	// MIDI frame length and interrupt point, in 1 MHz ticks
	localparam logic [8:0] MIDI_FRAME_TICKS = 9'd319;
	localparam logic [8:0] MIDI_INT_TICK    = 9'd15;

	localparam int         AUDIO_SUM_W = 19;
	localparam int         AUDIO_OUT_W = 16;
	localparam logic [7:0] OPEN_BUS    = 8'hFF;

	//==================================================================
	// Bus structs
	//==================================================================
	// Z80 bus, strobes already active high
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        mreq;
		logic        iorq;
		logic        rd;
		logic        wr;
		logic        m1;
	} cpu_bus_t;

	// One port write, strobe lasts a single cycle
	typedef struct packed {
		logic       strobe;
		logic [7:0] port;
		logic [7:0] data;
	} io_write_t;

	typedef struct packed {
		logic [7:0] lmpr;
		logic [7:0] hmpr;
		logic [7:0] ext_c;
		logic [7:0] ext_d;
		logic       ext_dis;
	} page_regs_t;

	typedef struct packed {
		logic [8:0] ram_page;
		logic       rom0_sel;
		logic       rom1_sel;
		logic       ext_ena;
		logic       ram_we;
		logic       ram_rd;
		logic [1:0] rom_addr_hi;
	} mem_sel_t;

endpackage

// File: src/sam_port_regs.sv
//======================================================================
// ASIC port registers
// Port write edge detection and the one-cycle write event
// LMPR, HMPR, border and external RAM page registers
// Port read multiplexer
//======================================================================

`timescale 1ns/1ns

module sam_port_regs (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  sam_pkg::cpu_bus_t    bus,
	input  logic                 ext_ram_off,
	input  logic                 int_midi,
	output sam_pkg::io_write_t   io_wr,
	output sam_pkg::page_regs_t  page_regs,
	output logic                 ear,
	output logic [7:0]           rdata
);

	logic       wr_cond;
	logic       wr_cond_q;
	logic       wr_edge;
	logic       wr_stb;
	logic [7:0] wr_port;
	logic [7:0] wr_data;
	logic       rd_cond;

	logic [7:0] lmpr;
	logic [7:0] hmpr;
	logic [7:0] border;
	logic [7:0] ext_c;
	logic [7:0] ext_d;
	logic       ext_dis;

	//==================================================================
	// Write event
	//==================================================================
	assign wr_cond = bus.iorq & bus.wr & bus.m1;
	assign wr_edge = wr_cond & ~wr_cond_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_cond_q <= 1'b0;
			wr_stb    <= 1'b0;
		end else begin
			wr_cond_q <= wr_cond;
			wr_stb    <= wr_edge;
		end
	end

	// Port and data captured with the edge, held until the next write
	always_ff @(posedge clk_sys) begin
		if (wr_edge) begin
			wr_port <= bus.addr[7:0];
			wr_data <= bus.wdata;
		end
	end

	assign io_wr = '{strobe: wr_stb, port: wr_port, data: wr_data};

	//==================================================================
	// ASIC registers
	//==================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			lmpr    <= 8'h00;
			hmpr    <= 8'h00;
			border  <= 8'h00;
			ext_c   <= 8'h00;
			ext_d   <= 8'h00;
			ext_dis <= ext_ram_off;
		end else if (io_wr.strobe) begin
			case (io_wr.port)
				sam_pkg::PORT_LMPR:   lmpr   <= io_wr.data;
				sam_pkg::PORT_HMPR:   hmpr   <= io_wr.data;
				sam_pkg::PORT_BORDER: border <= io_wr.data;
				sam_pkg::PORT_EXT_C:  ext_c  <= io_wr.data;
				sam_pkg::PORT_EXT_D:  ext_d  <= io_wr.data;
				default: ;
			endcase
		end
	end

	assign page_regs = '{
		lmpr:    lmpr,
		hmpr:    hmpr,
		ext_c:   ext_c,
		ext_d:   ext_d,
		ext_dis: ext_dis
	};

	// Beeper output bit of the border port
	assign ear = border[4];

	//==================================================================
	// Read multiplexer
	//==================================================================
	assign rd_cond = bus.iorq & bus.rd & bus.m1;

	always_comb begin
		rdata = sam_pkg::OPEN_BUS;
		if (rd_cond) begin
			case (bus.addr[7:0])
				// Line, frame and key bits read as inactive
				sam_pkg::PORT_STATUS:   rdata = {3'b111, ~int_midi, 4'b1111};
				sam_pkg::PORT_LMPR:     rdata = lmpr;
				sam_pkg::PORT_HMPR:     rdata = hmpr;
				sam_pkg::PORT_LPT_DATA,
				sam_pkg::PORT_LPT_STB:  rdata = 8'h00;
				default:                rdata = sam_pkg::OPEN_BUS;
			endcase
		end
	end

endmodule
